// File: src/nn_fmt_pkg.sv
package nn_fmt_pkg;

    localparam int NEURON_NUM   = 4;
    localparam int LAYER_NUM    = 3;
    localparam int LAYER_LAST   = LAYER_NUM - 1;  // output layer
    localparam int SAMPLE_NUM   = 16;

    localparam int ACT_WIDTH    = 16;
    localparam int DELTA_WIDTH  = 18;
    localparam int WEIGHT_WIDTH = 16;
    localparam int FRAC_WIDTH   = 8;              // shared by all formats
    localparam int LR_SHIFT     = 3;              // learning rate 1/8

    // clip limits
    localparam int DELTA_MAX  = 2**(DELTA_WIDTH-1) - 1;
    localparam int DELTA_MIN  = -(2**(DELTA_WIDTH-1));
    localparam int WEIGHT_MAX = 2**(WEIGHT_WIDTH-1) - 1;
    localparam int WEIGHT_MIN = -(2**(WEIGHT_WIDTH-1));

    localparam int W_DIAG_INIT = 128;  // 0.5
    localparam int W_OFF_INIT  = 16;   // 1/16

    typedef logic signed [ACT_WIDTH-1:0]    act_t;
    typedef logic signed [DELTA_WIDTH-1:0]  delta_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    typedef act_t    [NEURON_NUM-1:0] act_vec_t;
    typedef delta_t  [NEURON_NUM-1:0] delta_vec_t;
    typedef weight_t [NEURON_NUM-1:0] weight_row_t;

    // row j = outgoing neuron j, cell k = weight from previous neuron k
    typedef weight_row_t [NEURON_NUM-1:0] weight_mat_t;

    // w_jk * delta_j, one cell per k
    typedef delta_t [NEURON_NUM-1:0] prod_row_t;

    typedef logic [1:0] layer_t;
    typedef logic [3:0] sample_t;
    typedef logic [$clog2(NEURON_NUM)-1:0] neuron_t;

endpackage

// File: src/bp_ctrl_pkg.sv
package bp_ctrl_pkg;

    import nn_fmt_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        PROP_MUL,
        PROP_SUM,
        UPDATE,
        DONE
    } bp_state_t;

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_BAD_LAYER,
        ERR_NO_DELTA,
        ERR_SATURATE
    } bp_err_t;

    typedef struct packed {
        layer_t   layer;
        sample_t  sample;
        act_vec_t z;       // pre-activations of this layer
        act_vec_t z_prev;  // pre-activations of the layer below
    } bp_req_t;

    typedef struct packed {
        weight_mat_t weights;
        bp_err_t     err;
    } bp_res_t;

endpackage

// File: src/error_fetcher.sv
`timescale 1ns/100ps

module error_fetcher
    import nn_fmt_pkg::*;
    import bp_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  layer_t     layer,
    input  sample_t    sample,
    input  act_vec_t   z,
    input  delta_vec_t hidden_delta,
    input  logic       hidden_valid,
    output delta_vec_t delta,
    output logic       delta_valid,
    output bp_err_t    err
);

    // one 64-bit word per sample, target 0 in the low bits
    act_vec_t   targets [SAMPLE_NUM];
    act_vec_t   tgt;
    delta_vec_t delta_next;
    bp_err_t    err_next;

    initial begin
        $readmemh("targets.hex", targets);
    end

    assign tgt = targets[sample];

    always_comb begin
        err_next   = ERR_NONE;
        delta_next = '0;
        if (layer > layer_t'(LAYER_LAST)) begin
            err_next = ERR_BAD_LAYER;
        end else if (layer == layer_t'(LAYER_LAST)) begin
            for (int k = 0; k < NEURON_NUM; k++) begin
                // relu derivative masks inactive outputs
                if ($signed(z[k]) > 0) begin
                    delta_next[k] = $signed(z[k]) - $signed(tgt[k]);
                end
            end
        end else if (hidden_valid) begin
            delta_next = hidden_delta;  // error from the layer above
        end else begin
            err_next = ERR_NO_DELTA;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            delta_valid <= 1'b0;
            err         <= ERR_NONE;
        end else begin
            delta_valid <= start;
            if (start) err <= err_next;
        end
    end

    always_ff @(posedge clk) begin
        if (start) delta <= delta_next;
    end

endmodule

// File: src/weight_row_updater.sv
`timescale 1ns/100ps

module weight_row_updater
    import nn_fmt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  neuron_t     row_index,  // fixed per instance
    input  layer_t      layer,
    input  delta_t      delta_j,
    input  act_vec_t    act,        // rectified z_prev
    input  logic        mul_en,
    input  logic        upd_en,
    output prod_row_t   prod,
    output weight_row_t row,
    output logic        row_sat
);

    weight_row_t           rows [LAYER_NUM];
    weight_row_t           old_row;
    weight_row_t           new_row;
    prod_row_t             prod_next;
    logic [NEURON_NUM-1:0] clip;
    logic                  in_range;

    assign in_range = (layer <= layer_t'(LAYER_LAST));
    assign old_row  = in_range ? rows[layer] : '0;
    assign row      = old_row;

    always_comb begin
        logic signed [WEIGHT_WIDTH+DELTA_WIDTH-1:0] full;
        logic signed [DELTA_WIDTH+ACT_WIDTH:0]      step;
        logic signed [DELTA_WIDTH+ACT_WIDTH:0]      upd;
        for (int k = 0; k < NEURON_NUM; k++) begin
            full = ($signed(old_row[k]) * $signed(delta_j)) >>> FRAC_WIDTH;
            if (full > DELTA_MAX) prod_next[k] = delta_t'(DELTA_MAX);
            else if (full < DELTA_MIN) prod_next[k] = delta_t'(DELTA_MIN);
            else prod_next[k] = full[DELTA_WIDTH-1:0];

            step = ($signed(delta_j) * $signed(act[k])) >>> (FRAC_WIDTH + LR_SHIFT);
            upd  = $signed(old_row[k]) - step;
            clip[k] = 1'b1;
            if (upd > WEIGHT_MAX) new_row[k] = weight_t'(WEIGHT_MAX);
            else if (upd < WEIGHT_MIN) new_row[k] = weight_t'(WEIGHT_MIN);
            else begin
                new_row[k] = upd[WEIGHT_WIDTH-1:0];
                clip[k]    = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LAYER_NUM; l++) begin
                for (int k = 0; k < NEURON_NUM; k++) begin
                    rows[l][k] <= (k == row_index) ? weight_t'(W_DIAG_INIT) : weight_t'(W_OFF_INIT);
                end
            end
            row_sat <= 1'b0;
        end else begin
            row_sat <= 1'b0;  // pulse, valid while the result is taken
            if (upd_en && in_range) begin
                rows[layer] <= new_row;
                row_sat     <= |clip;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_en) prod <= prod_next;  // uses weights before update
    end

endmodule

// File: src/error_propagator.sv
`timescale 1ns/100ps

module error_propagator
    import nn_fmt_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sum_en,
    input  prod_row_t  prods [NEURON_NUM],
    input  act_vec_t   z_prev,
    output delta_vec_t hidden_delta,
    output logic       hidden_valid,
    output logic       sat_flag
);

    delta_vec_t            sum_next;
    logic [NEURON_NUM-1:0] clip;

    always_comb begin
        logic signed [DELTA_WIDTH+$clog2(NEURON_NUM)-1:0] acc;
        for (int k = 0; k < NEURON_NUM; k++) begin
            acc = '0;
            for (int j = 0; j < NEURON_NUM; j++) begin
                acc = acc + $signed(prods[j][k]);  // column k over all rows
            end
            clip[k]     = 1'b0;
            sum_next[k] = '0;
            if ($signed(z_prev[k]) > 0) begin
                if (acc > DELTA_MAX) begin
                    sum_next[k] = delta_t'(DELTA_MAX);
                    clip[k]     = 1'b1;
                end else if (acc < DELTA_MIN) begin
                    sum_next[k] = delta_t'(DELTA_MIN);
                    clip[k]     = 1'b1;
                end else begin
                    sum_next[k] = acc[DELTA_WIDTH-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hidden_valid <= 1'b0;
            sat_flag     <= 1'b0;
        end else if (sum_en) begin
            hidden_valid <= 1'b1;  // sticky until reset
            sat_flag     <= |clip;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_en) hidden_delta <= sum_next;  // kept for next hidden-layer request
    end

endmodule

// File: src/backpropagator.sv
`timescale 1ns/100ps

module backpropagator
    import nn_fmt_pkg::*;
    import bp_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  bp_req_t req,
    input  logic    req_valid,
    output logic    req_ready,
    output bp_res_t res,
    output logic    res_valid
);

    bp_state_t             state;
    bp_req_t               req_q;
    logic                  accept;
    logic                  mul_en;
    logic                  sum_en;
    logic                  upd_en;
    delta_vec_t            delta;
    delta_vec_t            hidden_delta;
    logic                  delta_valid;
    logic                  hidden_valid;
    logic                  sat_flag;
    bp_err_t               fetch_err;
    bp_err_t               res_err;
    act_vec_t              act;
    prod_row_t             prods [NEURON_NUM];
    weight_mat_t           rows;
    logic [NEURON_NUM-1:0] row_sat;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;
    assign mul_en    = (state == PROP_MUL);
    assign sum_en    = (state == PROP_SUM);
    assign upd_en    = (state == UPDATE);

    // a_k = relu(z_prev_k), shared by all rows
    always_comb begin
        for (int k = 0; k < NEURON_NUM; k++) begin
            act[k] = ($signed(req_q.z_prev[k]) > 0) ? req_q.z_prev[k] : '0;
        end
    end

    // fetch starts on the accepting edge, straight from the request
    error_fetcher u_fetch (
        .clk         (clk),
        .rst         (rst),
        .start       (accept),
        .layer       (req.layer),
        .sample      (req.sample),
        .z           (req.z),
        .hidden_delta(hidden_delta),
        .hidden_valid(hidden_valid),
        .delta       (delta),
        .delta_valid (delta_valid),
        .err         (fetch_err)
    );

    for (genvar i = 0; i < NEURON_NUM; i++) begin : g_row
        weight_row_updater u_row (
            .clk      (clk),
            .rst      (rst),
            .row_index(neuron_t'(i)),
            .layer    (req_q.layer),
            .delta_j  (delta[i]),
            .act      (act),
            .mul_en   (mul_en),
            .upd_en   (upd_en),
            .prod     (prods[i]),
            .row      (rows[i]),
            .row_sat  (row_sat[i])
        );
    end

    error_propagator u_prop (
        .clk         (clk),
        .rst         (rst),
        .sum_en      (sum_en),
        .prods       (prods),
        .z_prev      (req_q.z_prev),
        .hidden_delta(hidden_delta),
        .hidden_valid(hidden_valid),
        .sat_flag    (sat_flag)
    );

    always_comb begin
        if (fetch_err != ERR_NONE) res_err = fetch_err;  // early errors win
        else if (sat_flag || (|row_sat)) res_err = ERR_SATURATE;
        else res_err = ERR_NONE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                IDLE:     if (accept) state <= FETCH;
                FETCH:    if (delta_valid) state <= (fetch_err == ERR_NONE) ? PROP_MUL : DONE;
                PROP_MUL: state <= PROP_SUM;
                PROP_SUM: state <= UPDATE;
                UPDATE:   state <= DONE;
                DONE: begin
                    state     <= IDLE;
                    res_valid <= 1'b1;
                end
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_q <= req;
        if (state == DONE) begin
            res.weights <= rows;  // already updated, or untouched on early error
            res.err     <= res_err;
        end
    end

endmodule

// File: tb/backpropagator_assert.sv
`timescale 1ns/100ps

module backpropagator_assert
    import bp_ctrl_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    req_valid,
    input logic    req_ready,
    input logic    res_valid,
    input bp_err_t fetch_err
);

    logic accept;

    assign accept = req_valid && req_ready;

    reset_idle: assert property (@(posedge clk) $past(rst) |-> (req_ready && !res_valid))
        else $error("engine not idle after reset");

    res_pulse: assert property (@(posedge clk) disable iff (rst) res_valid |=> !res_valid)
        else $error("res_valid longer than one cycle");

    busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        accept |=> !req_ready)
        else $error("req_ready high right after acceptance");

    ready_with_result: assert property (@(posedge clk) disable iff (rst)
        $rose(req_ready) |-> res_valid)
        else $error("req_ready back before res_valid");

    // fetch_err is registered on the accepting edge
    normal_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(accept, 6) && ($past(fetch_err, 5) == ERR_NONE)) |-> res_valid)
        else $error("normal result not 5 cycles after acceptance");

    early_latency: assert property (@(posedge clk) disable iff (rst)
        $past(accept, 3) |-> (res_valid == ($past(fetch_err, 2) != ERR_NONE)))
        else $error("early error result at wrong cycle");

endmodule

bind backpropagator backpropagator_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .res_valid(res_valid),
    .fetch_err(fetch_err)
);

// File: tb/tb_backpropagator.sv
`timescale 1ns/100ps

module tb_backpropagator
    import nn_fmt_pkg::*;
    import bp_ctrl_pkg::*;
();

    typedef logic signed [39:0] wide_t;

    logic        clk;
    logic        rst;
    bp_req_t     req;
    logic        req_valid;
    logic        req_ready;
    bp_res_t     res;
    logic        res_valid;

    weight_mat_t wm [LAYER_NUM];  // reference weights
    delta_vec_t  hid;             // reference hidden error
    logic        hid_ok;
    act_vec_t    tgt [SAMPLE_NUM];
    bp_res_t     exp_q [$];
    int          errors;
    int          results;
    int          sent;

    backpropagator UUT (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .res      (res),
        .res_valid(res_valid)
    );

    always #2 clk = ~clk;

    function automatic wide_t clamp(input wide_t v, input int w);
        wide_t hi;
        hi = (wide_t'(1) <<< (w - 1)) - 1;
        if (v > hi) return hi;
        if (v < -hi - 1) return -hi - 1;
        return v;
    endfunction

    task automatic predict(input bp_req_t r, output bp_res_t e);
        delta_vec_t d;
        wide_t      col [NEURON_NUM];
        wide_t      v;
        wide_t      u;
        logic       sat;
        sat = 1'b0;
        d = '0;
        e.weights = '0;
        e.err = ERR_NONE;
        if (r.layer > layer_t'(LAYER_LAST)) begin
            e.err = ERR_BAD_LAYER;
        end else if (r.layer != layer_t'(LAYER_LAST) && !hid_ok) begin
            e.err = ERR_NO_DELTA;
            e.weights = wm[r.layer];
        end else begin
            for (int k = 0; k < NEURON_NUM; k++) begin
                col[k] = '0;
                v = $signed(r.z[k]);
                v = v - $signed(tgt[r.sample][k]);  // output error, relu masked
                if (r.layer != layer_t'(LAYER_LAST)) d[k] = hid[k];
                else if ($signed(r.z[k]) > 0) d[k] = v[DELTA_WIDTH-1:0];
            end
            for (int j = 0; j < NEURON_NUM; j++) begin
                for (int k = 0; k < NEURON_NUM; k++) begin
                    v = $signed(wm[r.layer][j][k]) * $signed(d[j]);
                    col[k] = col[k] + clamp(v >>> FRAC_WIDTH, DELTA_WIDTH);  // old weight
                    u = ($signed(r.z_prev[k]) > 0) ? $signed(r.z_prev[k]) : 0;
                    v = (u * $signed(d[j])) >>> (FRAC_WIDTH + LR_SHIFT);
                    v = $signed(wm[r.layer][j][k]) - v;
                    u = clamp(v, WEIGHT_WIDTH);
                    sat = sat | (u != v);
                    wm[r.layer][j][k] = u[WEIGHT_WIDTH-1:0];
                end
            end
            for (int k = 0; k < NEURON_NUM; k++) begin
                v = ($signed(r.z_prev[k]) > 0) ? clamp(col[k], DELTA_WIDTH) : '0;
                sat = sat | (($signed(r.z_prev[k]) > 0) && (v != col[k]));
                hid[k] = v[DELTA_WIDTH-1:0];
            end
            hid_ok = 1'b1;
            e.weights = wm[r.layer];
            e.err = sat ? ERR_SATURATE : ERR_NONE;
        end
    endtask

    function automatic bp_req_t make_req(input layer_t l, input sample_t s, input int span);
        bp_req_t r;
        r.layer = l;
        r.sample = s;
        for (int k = 0; k < NEURON_NUM; k++) begin
            r.z[k] = act_t'(int'($urandom % (2 * span)) - span);
            r.z_prev[k] = act_t'(int'($urandom % (2 * span)) - span);
        end
        return r;
    endfunction

    // valid goes up at once and stays up while the engine is busy
    task automatic send(input bp_req_t r);
        bp_res_t e;
        int      t;
        t = 0;
        req = r;
        req_valid = 1'b1;
        while (!req_ready && t < 200) begin
            @(posedge clk);
            #0.5;
            t++;
        end
        if (!req_ready) begin
            $display("ERROR at %0t: request not accepted within 200 cycles", $time);
            errors++;
        end else begin
            predict(r, e);
            exp_q.push_back(e);
            sent++;
        end
        @(posedge clk);
        #0.5;
        req_valid = 1'b0;
    endtask

    always @(negedge clk) begin : check_res
        bp_res_t e;
        if (!rst && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: result seen with no request pending", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                results++;
                assert (res.err == e.err) else begin
                    $display("CHECK FAILED at %0t: res.err got %0d expected %0d",
                             $time, res.err, e.err);
                    errors++;
                end
                assert (res.weights == e.weights) else begin
                    $display("CHECK FAILED at %0t: res.weights got %h expected %h",
                             $time, res.weights, e.weights);
                    errors++;
                end
            end
        end
    end

    initial begin : stimulus
        bp_req_t r;
        int      t;
        void'($urandom(32'h66ed3a84));
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        errors = 0;
        results = 0;
        sent = 0;
        hid = '0;
        hid_ok = 1'b0;
        $readmemh("tb/targets.hex", tgt);
        for (int l = 0; l < LAYER_NUM; l++) begin
            for (int j = 0; j < NEURON_NUM; j++) begin
                for (int k = 0; k < NEURON_NUM; k++) begin
                    wm[l][j][k] = (j == k) ? weight_t'(W_DIAG_INIT) : weight_t'(W_OFF_INIT);
                end
            end
        end
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;

        send(make_req(1, 0, 256));  // nothing propagated yet
        for (int i = 0; i < 6; i++) begin
            send(make_req(layer_t'(LAYER_LAST), sample_t'(i * 5), 512));
            send(make_req(1, sample_t'(i), 512));
            send(make_req(0, sample_t'(i + 8), 512));
        end
        send(make_req(3, 4, 256));
        send(make_req(layer_t'(LAYER_LAST), 7, 512));  // weights survive the bad layer
        r = make_req(layer_t'(LAYER_LAST), 9, 16);
        r.z = {4{16'sh7fff}};
        r.z_prev = {4{16'sh7fff}};
        send(r);
        send(make_req(1, 2, 512));

        t = 0;
        while (results < sent && t < 200) begin
            @(posedge clk);
            t++;
        end
        if (results < sent) begin
            $display("ERROR: %0d results still missing after 200 cycles", sent - results);
            errors++;
        end
        $display("requests: %0d, results: %0d, errors: %0d", sent, results, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tb/targets.hex
// one 64-bit word per sample, line n is sample n
// columns left to right: target3 target2 target1 target0, signed 8.8 hex
0100008000c0ff80
ff000040012000a0
00800100ffc00060
0040ff800080ffe0
00c0002001000010
ff40010000a0ff00
0020ffa000e00140
0180ff60003000c0
ffe000b0ff900100
0070ff2001400050
00a00060ffa000f0
ff8000d00010ff70
0110ffb000900030
ffd00130ff600080
00500090ffe00120
0160ff7000b0ff50

// File: backpropagator.f
src/nn_fmt_pkg.sv
src/bp_ctrl_pkg.sv
src/error_fetcher.sv
src/weight_row_updater.sv
src/error_propagator.sv
src/backpropagator.sv
tb/backpropagator_assert.sv
tb/tb_backpropagator.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_backpropagator
FILELIST  = backpropagator.f
OBJ_DIR   = obj_dir
LOG       = sim.log
DATA      = tb/targets.hex

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	cp $(DATA) targets.hex
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG) targets.hex
